/* Makefile */
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vrbm_top_tb: src.f $(SRCS)
	verilator --binary --timing --assert --top-module rbm_top_tb -f src.f

run: obj_dir/Vrbm_top_tb
	@out="$$(./obj_dir/Vrbm_top_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* common/rbm_map_pkg.sv */
`default_nettype none

package rbm_map_pkg;

   // layer widths
   localparam int VIS_DIM = 16;
   localparam int HID_DIM = 8;
   localparam int OUT_DIM = 4;

   localparam int ADDR_BITS = 8;
   typedef logic [ADDR_BITS-1:0] waddr_t;

   // weights of neuron j are contiguous, input i at base + j*in_dim + i
   localparam int L0_W_BASE = 0;
   localparam int L0_B_BASE = L0_W_BASE + VIS_DIM * HID_DIM;

   localparam int L1_W_BASE = L0_B_BASE + HID_DIM;
   localparam int L1_B_BASE = L1_W_BASE + HID_DIM * OUT_DIM;

   // 172 words in total
   localparam int MEM_WORDS = L1_B_BASE + OUT_DIM;

endpackage

`default_nettype wire

/* common/rbm_num_pkg.sv */
`default_nettype none

package rbm_num_pkg;

   // signed fixed point, 6 fraction bits
   localparam int W_BITS = 12;
   localparam int P_BITS = 8;

   // sigmoid slope and midpoint
   localparam int SIG_SHIFT = 2;
   localparam int PROB_HALF = 128;

   typedef logic signed [W_BITS-1:0] weight_t;
   typedef logic [P_BITS-1:0] prob_t;

   localparam weight_t SAT_MAX = 12'sh7ff;
   localparam weight_t SAT_MIN = 12'sh800;

   function automatic weight_t sat_add(input weight_t a, input weight_t b);
      logic signed [W_BITS:0] sum;
      sum = {a[W_BITS-1], a} + {b[W_BITS-1], b};
      // the two top bits differ only on overflow
      if (sum[W_BITS] != sum[W_BITS-1]) begin
         return sum[W_BITS] ? SAT_MIN : SAT_MAX;
      end
      return weight_t'(sum[W_BITS-1:0]);
   endfunction

   function automatic prob_t sigmoid_pwl(input weight_t x);
      logic signed [W_BITS-1:0] t;
      t = (x >>> SIG_SHIFT) + W_BITS'(PROB_HALF);
      if (t < 0) begin
         return '0;
      end
      if (t > W_BITS'((1 << P_BITS) - 1)) begin
         return '1;
      end
      return prob_t'(t[P_BITS-1:0]);
   endfunction

endpackage

`default_nettype wire

/* common/wmem_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface wmem_if
   import rbm_num_pkg::*, rbm_map_pkg::*;
();

   logic    req;
   waddr_t  addr;
   logic    grant;
   weight_t rdata;

   // req and addr stay up until grant, rdata follows one cycle later
   modport requester (
      output req,
      output addr,
      input  grant,
      input  rdata
   );

   modport arbiter (
      input  req,
      input  addr,
      output grant,
      output rdata
   );

endinterface

`default_nettype wire

/* hdl/rbm_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rbm_top
   import rbm_num_pkg::*, rbm_map_pkg::*;
(
   input  logic               clock,
   input  logic               reset,
   input  logic               load_en,
   input  waddr_t             load_addr,
   input  weight_t            load_data,
   input  logic               start,
   input  logic [VIS_DIM-1:0] visible,
   output logic               ready,
   output logic               hidden_valid,
   output logic [HID_DIM-1:0] hidden,
   output logic               out_valid,
   output logic [OUT_DIM-1:0] out
);

   wmem_if l0_mem ();
   wmem_if l1_mem ();

   logic    rd_en;
   waddr_t  rd_addr;
   weight_t rd_data;

   logic l0_start;
   logic l0_done;
   logic l0_busy;
   logic l1_start;
   logic l1_done;
   logic l1_busy;

   // layer 0 result waiting for layer 1 to free up
   logic handoff_pend;

   assign ready    = ~l0_busy & ~handoff_pend;
   assign l0_start = start & ready;
   assign l1_start = (l0_done | handoff_pend) & ~l1_busy;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         handoff_pend <= 1'b0;
      end else if (l0_done & l1_busy) begin
         handoff_pend <= 1'b1;
      end else if (l1_start) begin
         handoff_pend <= 1'b0;
      end
   end

   assign hidden_valid = l0_done;
   assign out_valid    = l1_done;

   weight_memory u_mem (
      .clock     (clock),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   wmem_arbiter u_arb (
      .clock   (clock),
      .reset   (reset),
      .port_a  (l0_mem.arbiter),
      .port_b  (l1_mem.arbiter),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   rbm_layer #(
      .IN_DIM    (VIS_DIM),
      .OUT_DIM_P (HID_DIM),
      .W_BASE    (L0_W_BASE),
      .B_BASE    (L0_B_BASE),
      .SEED      (8'h5a)
   ) u_layer0 (
      .clock    (clock),
      .reset    (reset),
      .start    (l0_start),
      .in_bits  (visible),
      .mem      (l0_mem.requester),
      .done     (l0_done),
      .out_bits (hidden),
      .busy     (l0_busy)
   );

   // hidden stays stable until layer 0 samples again, so layer 1 can take it late
   rbm_layer #(
      .IN_DIM    (HID_DIM),
      .OUT_DIM_P (OUT_DIM),
      .W_BASE    (L1_W_BASE),
      .B_BASE    (L1_B_BASE),
      .SEED      (8'hc3)
   ) u_layer1 (
      .clock    (clock),
      .reset    (reset),
      .start    (l1_start),
      .in_bits  (hidden),
      .mem      (l1_mem.requester),
      .done     (l1_done),
      .out_bits (out),
      .busy     (l1_busy)
   );

endmodule

`default_nettype wire

/* hdl/weight_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module weight_memory
   import rbm_num_pkg::*, rbm_map_pkg::*;
(
   input  logic    clock,
   input  logic    load_en,
   input  waddr_t  load_addr,
   input  weight_t load_data,
   input  logic    rd_en,
   input  waddr_t  rd_addr,
   output weight_t rd_data
);

   weight_t mem [MEM_WORDS];

   // single port, a load wins over a read
   always_ff @(posedge clock) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end else if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

/* hdl/wmem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module wmem_arbiter
   import rbm_num_pkg::*, rbm_map_pkg::*;
(
   input  logic    clock,
   input  logic    reset,
   wmem_if.arbiter port_a,
   wmem_if.arbiter port_b,
   output logic    rd_en,
   output waddr_t  rd_addr,
   input  weight_t rd_data
);

   // high when port b wins a tie
   logic prio_b;
   logic gnt_a;
   logic gnt_b;

   assign gnt_a = port_a.req & (~port_b.req | ~prio_b);
   assign gnt_b = port_b.req & (~port_a.req | prio_b);

   assign port_a.grant = gnt_a;
   assign port_b.grant = gnt_b;

   assign rd_en   = gnt_a | gnt_b;
   assign rd_addr = gnt_b ? port_b.addr : port_a.addr;

   // both see the data, each takes it only after its own grant
   assign port_a.rdata = rd_data;
   assign port_b.rdata = rd_data;

   // the loser of the last grant goes first next time
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         prio_b <= 1'b0;
      end else if (gnt_a) begin
         prio_b <= 1'b1;
      end else if (gnt_b) begin
         prio_b <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* rbm_layer/neuron_sampler.sv */
`timescale 1ns/100ps
`default_nettype none

module neuron_sampler
   import rbm_num_pkg::*;
#(
   parameter prob_t SEED = 8'h5a
) (
   input  logic    clock,
   input  logic    reset,
   input  weight_t acc,
   input  logic    sample,
   output logic    fire
);

   localparam prob_t LFSR_TAPS = 8'hb8;

   prob_t lfsr;
   prob_t prob;

   assign prob = sigmoid_pwl(acc);
   assign fire = prob > lfsr;

   // galois form, shifts right and folds the taps in on a one
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         lfsr <= SEED;
      end else if (sample) begin
         lfsr <= {1'b0, lfsr[P_BITS-1:1]} ^ (lfsr[0] ? LFSR_TAPS : prob_t'(0));
      end
   end

endmodule

`default_nettype wire

/* rbm_layer/rbm_layer.sv */
`timescale 1ns/100ps
`default_nettype none

module rbm_layer
   import rbm_num_pkg::*, rbm_map_pkg::*;
#(
   parameter int          IN_DIM    = 16,
   parameter int          OUT_DIM_P = 8,
   parameter int          W_BASE    = 0,
   parameter int          B_BASE    = 128,
   parameter logic [7:0]  SEED      = 8'h5a
) (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 start,
   input  logic [IN_DIM-1:0]    in_bits,
   wmem_if.requester            mem,
   output logic                 done,
   output logic [OUT_DIM_P-1:0] out_bits,
   output logic                 busy
);

   localparam int IW = (IN_DIM > 1) ? $clog2(IN_DIM) : 1;
   localparam int NW = (OUT_DIM_P > 1) ? $clog2(OUT_DIM_P) : 1;

   localparam logic [IW-1:0] W_LAST = IW'(IN_DIM - 1);
   localparam logic [NW-1:0] N_LAST = NW'(OUT_DIM_P - 1);

   localparam logic [2:0] S_IDLE   = 3'd0;
   localparam logic [2:0] S_REQ    = 3'd1;
   localparam logic [2:0] S_DATA   = 3'd2;
   localparam logic [2:0] S_SAMPLE = 3'd3;
   localparam logic [2:0] S_DONE   = 3'd4;

   logic [2:0]        state;
   logic [NW-1:0]     n_idx;
   logic [IW-1:0]     w_idx;
   logic              bias_phase;
   waddr_t            w_addr;
   waddr_t            b_addr;
   logic [IN_DIM-1:0] in_reg;
   weight_t           acc;
   logic              sample;
   logic              fire;

   assign mem.req  = (state == S_REQ);
   assign mem.addr = bias_phase ? b_addr : w_addr;

   assign sample = (state == S_SAMPLE);
   assign done   = (state == S_DONE);
   assign busy   = (state != S_IDLE);

   neuron_sampler #(
      .SEED (SEED)
   ) u_sampler (
      .clock  (clock),
      .reset  (reset),
      .acc    (acc),
      .sample (sample),
      .fire   (fire)
   );

   // sequencer: bias read, then one read per input, then a sample cycle
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state      <= S_IDLE;
         n_idx      <= '0;
         w_idx      <= '0;
         bias_phase <= 1'b1;
         w_addr     <= '0;
         b_addr     <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (start) begin
                  n_idx      <= '0;
                  w_idx      <= '0;
                  bias_phase <= 1'b1;
                  w_addr     <= waddr_t'(W_BASE);
                  b_addr     <= waddr_t'(B_BASE);
                  state      <= S_REQ;
               end
            end
            S_REQ: begin
               if (mem.grant) begin
                  state <= S_DATA;
               end
            end
            S_DATA: begin
               if (bias_phase) begin
                  bias_phase <= 1'b0;
                  b_addr     <= b_addr + 1'b1;
                  state      <= S_REQ;
               end else begin
                  w_addr <= w_addr + 1'b1;
                  if (w_idx == W_LAST) begin
                     w_idx <= '0;
                     state <= S_SAMPLE;
                  end else begin
                     w_idx <= w_idx + 1'b1;
                     state <= S_REQ;
                  end
               end
            end
            S_SAMPLE: begin
               if (n_idx == N_LAST) begin
                  state <= S_DONE;
               end else begin
                  n_idx      <= n_idx + 1'b1;
                  bias_phase <= 1'b1;
                  state      <= S_REQ;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // datapath, rdata is taken in the cycle after the grant
   always_ff @(posedge clock) begin
      if (state == S_IDLE && start) begin
         in_reg <= in_bits;
      end
      if (state == S_DATA) begin
         if (bias_phase) begin
            acc <= mem.rdata;
         end else if (in_reg[w_idx]) begin
            acc <= sat_add(acc, mem.rdata);
         end
      end
      // held after done until the next sample overwrites it
      if (sample) begin
         out_bits[n_idx] <= fire;
      end
   end

endmodule

`default_nettype wire

/* src.f */
common/rbm_num_pkg.sv
common/rbm_map_pkg.sv
common/wmem_if.sv
hdl/weight_memory.sv
hdl/wmem_arbiter.sv
rbm_layer/neuron_sampler.sv
rbm_layer/rbm_layer.sv
hdl/rbm_top.sv
verification/rbm_top_asserts.sv
verification/rbm_top_tb.sv

/* verification/rbm_testdata.txt */
// weight memory words in address order, 12-bit two's complement hex, then 16-bit visible words
// layer 0 weights, one neuron per line, input 0 first
7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff
800 800 800 800 800 800 800 800 800 800 800 800 800 800 800 800
040 fc0 080 f80 020 fe0 100 f00 040 fc0 080 f80 020 fe0 100 f00
100 100 080 080 f80 f80 000 000 0c0 f40 040 040 fc0 fc0 020 fe0
300 300 300 300 300 300 300 300 d00 d00 d00 d00 d00 d00 d00 d00
010 020 030 040 050 060 070 080 f90 fa0 fb0 fc0 fd0 fe0 ff0 000
080 f80 080 f80 080 f80 080 f80 080 f80 080 f80 080 f80 080 f80
0a0 060 f40 0e0 f20 040 0c0 fa0 030 fd0 070 f90 0b0 f50 010 ff0
// layer 0 biases
000 040 fc0 020 000 f80 010 ff0
// layer 1 weights, two neurons per line
100 f00 080 f80 040 fc0 020 fe0 0c0 0c0 0c0 0c0 f40 f40 f40 f40
7ff 7ff 7ff 7ff 7ff 7ff 7ff 7ff 800 400 c00 200 e00 100 f00 080
// layer 1 biases
020 fe0 000 040
// visible vectors: single, back to back, all ones, none, then one vector repeated
a5c3
0f0f f0f0 1234
ffff
0000
3c3c 3c3c 3c3c 3c3c

/* verification/rbm_top_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module rbm_top_asserts
   import rbm_map_pkg::*;
(
   input  logic   clock,
   input  logic   reset,
   input  logic   req_a,
   input  waddr_t addr_a,
   input  logic   gnt_a,
   input  logic   req_b,
   input  waddr_t addr_b,
   input  logic   gnt_b
);

   int fail_count = 0;

   one_grant: assert property (@(posedge clock) disable iff (reset) !(gnt_a && gnt_b))
      else begin fail_count++; $error("both weight memory grants high"); end

   grant_a_req: assert property (@(posedge clock) disable iff (reset) gnt_a |-> req_a)
      else begin fail_count++; $error("grant a without req a"); end

   grant_b_req: assert property (@(posedge clock) disable iff (reset) gnt_b |-> req_b)
      else begin fail_count++; $error("grant b without req b"); end

   // a waiting request keeps its address
   hold_a: assert property (@(posedge clock) disable iff (reset)
      req_a && !gnt_a |=> req_a && $stable(addr_a))
      else begin fail_count++; $error("req a dropped or moved before grant"); end

   hold_b: assert property (@(posedge clock) disable iff (reset)
      req_b && !gnt_b |=> req_b && $stable(addr_b))
      else begin fail_count++; $error("req b dropped or moved before grant"); end

endmodule

bind wmem_arbiter rbm_top_asserts u_asserts (
   .clock  (clock),
   .reset  (reset),
   .req_a  (port_a.req),
   .addr_a (port_a.addr),
   .gnt_a  (gnt_a),
   .req_b  (port_b.req),
   .addr_b (port_b.addr),
   .gnt_b  (gnt_b)
);

`default_nettype wire

/* verification/rbm_top_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rbm_top_tb
   import rbm_num_pkg::*, rbm_map_pkg::*;
();

   localparam int RESET_CYCLES    = 10;
   localparam int NUM_VECTORS     = 10;
   localparam int DATA_WORDS      = MEM_WORDS + NUM_VECTORS;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + MEM_WORDS + NUM_VECTORS * 400 + 100;

   logic               clock;
   logic               reset;
   logic               load_en;
   waddr_t             load_addr;
   weight_t            load_data;
   logic               start;
   logic [VIS_DIM-1:0] visible;
   logic               ready;
   logic               hidden_valid;
   logic [HID_DIM-1:0] hidden;
   logic               out_valid;
   logic [OUT_DIM-1:0] out;

   // bit 16 marks a word that the data file did not reach
   logic [16:0]        data_words [0:DATA_WORDS-1];
   logic [HID_DIM-1:0] hid_q [$];
   logic [OUT_DIM-1:0] out_q [$];

   // model copies of the two layer LFSRs
   prob_t lfsr_l0 = 8'h5a;
   prob_t lfsr_l1 = 8'hc3;

   int errors         = 0;
   int checks         = 0;
   int sent_count     = 0;
   int accepted_count = 0;
   int hid_count      = 0;
   int out_count      = 0;

   rbm_top uut (
      .clock        (clock),
      .reset        (reset),
      .load_en      (load_en),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .start        (start),
      .visible      (visible),
      .ready        (ready),
      .hidden_valid (hidden_valid),
      .hidden       (hidden),
      .out_valid    (out_valid),
      .out          (out)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   // 12-bit two's complement word from the data file
   function automatic int word_value(input int addr);
      int v;
      v = int'(data_words[addr][11:0]);
      if (v > 2047) begin
         v = v - 4096;
      end
      return v;
   endfunction

   function automatic int clamp_sum(input int a, input int b);
      int s;
      s = a + b;
      if (s > 2047) begin
         s = 2047;
      end else if (s < -2048) begin
         s = -2048;
      end
      return s;
   endfunction

   function automatic int prob_of(input int acc);
      int t;
      t = (acc >>> 2) + 128;
      if (t < 0) begin
         t = 0;
      end else if (t > 255) begin
         t = 255;
      end
      return t;
   endfunction

   function automatic prob_t lfsr_next(input prob_t s);
      prob_t n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 8'hb8;
      end
      return n;
   endfunction

   // both layers handle samples in order, so the model can run ahead at send time
   task automatic predict_vector(input logic [VIS_DIM-1:0] vec);
      logic [HID_DIM-1:0] h;
      logic [OUT_DIM-1:0] o;
      int                 acc;
      for (int j = 0; j < HID_DIM; j++) begin
         acc = word_value(L0_B_BASE + j);
         for (int i = 0; i < VIS_DIM; i++) begin
            if (vec[i]) begin
               acc = clamp_sum(acc, word_value(L0_W_BASE + j * VIS_DIM + i));
            end
         end
         h[j]    = prob_of(acc) > int'(lfsr_l0);
         lfsr_l0 = lfsr_next(lfsr_l0);
      end
      for (int k = 0; k < OUT_DIM; k++) begin
         acc = word_value(L1_B_BASE + k);
         for (int i = 0; i < HID_DIM; i++) begin
            if (h[i]) begin
               acc = clamp_sum(acc, word_value(L1_W_BASE + k * HID_DIM + i));
            end
         end
         o[k]    = prob_of(acc) > int'(lfsr_l1);
         lfsr_l1 = lfsr_next(lfsr_l1);
      end
      hid_q.push_back(h);
      out_q.push_back(o);
   endtask

   task automatic check_hidden(input logic [HID_DIM-1:0] got, input logic [HID_DIM-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %t: hidden got %b expected %b", $time, got, exp);
      end
   endtask

   task automatic check_out(input logic [OUT_DIM-1:0] got, input logic [OUT_DIM-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %t: out got %b expected %b", $time, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Fail at %t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic load_memory();
      for (int a = 0; a < MEM_WORDS; a++) begin
         @(posedge clock);
         load_en   <= 1'b1;
         load_addr <= waddr_t'(a);
         load_data <= weight_t'(data_words[a][11:0]);
      end
      @(posedge clock);
      load_en <= 1'b0;
   endtask

   // waits for ready, then gives a one-cycle start
   task automatic send_vector(input logic [VIS_DIM-1:0] vec);
      @(negedge clock);
      while (!ready) begin
         @(negedge clock);
      end
      @(posedge clock);
      start   <= 1'b1;
      visible <= vec;
      predict_vector(vec);
      sent_count++;
      @(posedge clock);
      start <= 1'b0;
   endtask

   task automatic send_while_busy(input logic [VIS_DIM-1:0] vec);
      @(negedge clock);
      while (ready) begin
         @(negedge clock);
      end
      @(posedge clock);
      start   <= 1'b1;
      visible <= vec;
      @(negedge clock);
      check_flag("ready", ready, 1'b0);
      @(posedge clock);
      start <= 1'b0;
   endtask

   task automatic wait_for_results(input int n);
      while (out_count < n) begin
         @(negedge clock);
      end
   endtask

   task automatic print_summary();
      $display("summary: %0d checks, %0d errors, %0d starts accepted, %0d hidden, %0d out",
               checks, errors, accepted_count, hid_count, out_count);
   endtask

   // outputs are sampled half a cycle after the driving edge
   initial begin
      forever begin
         @(negedge clock);
         if (!reset && start && ready) begin
            accepted_count++;
         end
         if (hidden_valid) begin
            hid_count++;
            if (hid_q.size() == 0) begin
               errors++;
               $display("hidden_valid came with no sample in flight at %t", $time);
            end else begin
               check_hidden(hidden, hid_q.pop_front());
            end
         end
         if (out_valid) begin
            out_count++;
            if (out_q.size() == 0) begin
               errors++;
               $display("out_valid came with no sample in flight at %t", $time);
            end else begin
               check_out(out, out_q.pop_front());
            end
         end
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clock);
      $display("timeout: a hidden_valid or out_valid strobe never came in %0d cycles",
               WATCHDOG_CYCLES);
      print_summary();
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      $timeformat(-9, 1, " ns", 10);
      reset     = 1'b1;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      start     = 1'b0;
      visible   = '0;
      for (int a = 0; a < DATA_WORDS; a++) begin
         data_words[a] = {1'b1, 16'(a)};
      end
      $readmemh("verification/rbm_testdata.txt", data_words);
      if (data_words[DATA_WORDS-1][16]) begin
         errors++;
         $display("data file holds fewer than %0d words", DATA_WORDS);
      end

      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      check_flag("ready", ready, 1'b1);
      check_flag("hidden_valid", hidden_valid, 1'b0);
      check_flag("out_valid", out_valid, 1'b0);

      load_memory();

      // one sample alone, plus a start that must be dropped while layer 0 is busy
      send_vector(data_words[MEM_WORDS][15:0]);
      send_while_busy(16'hffff);
      wait_for_results(1);

      // the rest back to back, includes the saturating and repeated vectors
      for (int v = 1; v < NUM_VECTORS; v++) begin
         send_vector(data_words[MEM_WORDS + v][15:0]);
      end
      wait_for_results(sent_count);
      repeat (5) @(negedge clock);

      check_count("hidden_valid strobes", hid_count, sent_count);
      check_count("out_valid strobes", out_count, sent_count);
      check_count("accepted starts", accepted_count, sent_count);
      errors = errors + uut.u_arb.u_asserts.fail_count;
      print_summary();
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
